/* design/radio_ctrl_pkg.sv */
package radio_ctrl_pkg;

   //============================================================
   // Register data and addressing types
   //============================================================
   typedef logic [7:0] data_byte_t;   // One register data byte
   typedef logic [4:0] ioc_t;         // Register address inside a module
   typedef logic [1:0] mod_sel_t;     // 0 sys, 1 I/O, 2 reserved, 3 unused
   typedef logic [3:0] cs_onehot_t;   // One bit per module select value

   //============================================================
   // RF front-end mode encoding
   //============================================================
   // Codes 6 and 7 are invalid
   typedef enum logic [2:0] {
      RF_LOW_POWER  = 3'd0,
      RF_RX_LOWPASS = 3'd1,
      RF_RX_HIPASS  = 3'd2,
      RF_TX_LOWPASS = 3'd3,
      RF_TX_HIPASS  = 3'd4,
      RF_BYPASS     = 3'd5
   } rf_mode_t;

   //============================================================
   // Register map
   //============================================================
   // System block
   localparam ioc_t IOC_SYS_VERSION    = 5'd0;  // Read-only firmware version
   localparam ioc_t IOC_SYS_STATUS     = 5'd1;  // Read-only error summary
   localparam ioc_t IOC_SYS_SOFT_RESET = 5'd2;  // Any write resets the I/O block
   localparam ioc_t IOC_SYS_SCRATCH    = 5'd3;  // Free read/write byte

   // I/O block
   localparam ioc_t IOC_IO_RF_MODE = 5'd1;      // rf_mode_t in bits 2:0
   localparam ioc_t IOC_IO_LEDS    = 5'd2;      // led0, led1, ldo enable
   localparam ioc_t IOC_IO_INPUTS  = 5'd3;      // Button and config straps
   localparam ioc_t IOC_IO_MIXER   = 5'd4;      // Mixer enable and FM

   // Fixed readback of the reserved module select
   localparam data_byte_t RESERVED_PATTERN = 8'hA5;

endpackage

/* design/spi_if.sv */
`timescale 1ns/1ns

module spi_if (
   input  logic                      i_glob_clock,
   input  logic                      i_reset,
   input  logic                      i_spi_sck,
   input  logic                      i_spi_mosi,
   input  logic                      i_spi_cs_b,
   input  radio_ctrl_pkg::data_byte_t i_data_out,   // Registered readback from top
   output logic                      o_spi_miso,
   output radio_ctrl_pkg::ioc_t      o_ioc,
   output radio_ctrl_pkg::data_byte_t o_data_in,
   output radio_ctrl_pkg::cs_onehot_t o_cs,
   output logic                      o_fetch_cmd,
   output logic                      o_load_cmd
);
   import radio_ctrl_pkg::*;

   //============================================================
   // Synchronizers and edge detection
   //============================================================
   logic [2:0] r_sck_sync;    // Two sync flops plus one for edge history
   logic [1:0] r_mosi_sync;
   logic [1:0] r_cs_b_sync;

   logic       w_sck_rise;
   logic       w_sck_fall;
   logic       w_cs_b;

   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         r_sck_sync  <= 3'b000;
         r_mosi_sync <= 2'b00;
         r_cs_b_sync <= 2'b11;           // Idle is deselected
      end else begin
         r_sck_sync  <= {r_sck_sync[1:0], i_spi_sck};
         r_mosi_sync <= {r_mosi_sync[0], i_spi_mosi};
         r_cs_b_sync <= {r_cs_b_sync[0], i_spi_cs_b};
      end
   end

   assign w_sck_rise = r_sck_sync[1] & ~r_sck_sync[2];
   assign w_sck_fall = ~r_sck_sync[1] & r_sck_sync[2];
   assign w_cs_b     = r_cs_b_sync[1];

   //============================================================
   // Bit counter and frame decode
   //============================================================
   logic [4:0]  r_bit_cnt;      // Saturates at 16
   logic [7:0]  r_shift;        // MOSI shift register
   logic        r_write;        // Write flag from byte 1
   logic [7:0]  r_miso_shift;   // Readback shifted out MSB first
   data_byte_t  w_byte;         // Byte including the bit sampled now
   mod_sel_t    w_mod_sel;

   assign w_byte    = {r_shift[6:0], r_mosi_sync[1]};
   assign w_mod_sel = w_byte[6:5];

   // Payload shifter
   always_ff @(posedge i_glob_clock) begin
      if (w_sck_rise) begin
         r_shift <= w_byte;
      end
      if (w_sck_rise && !w_cs_b && r_bit_cnt == 5'd7) begin
         o_ioc <= w_byte[4:0];                     // Address held for the whole frame
      end
      if (w_sck_rise && !w_cs_b && r_bit_cnt == 5'd15) begin
         o_data_in <= w_byte;                      // Write data byte
      end
   end

   // Framing control
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         r_bit_cnt    <= 5'd0;
         r_write      <= 1'b0;
         r_miso_shift <= 8'h00;
         o_cs         <= '0;
         o_fetch_cmd  <= 1'b0;
         o_load_cmd   <= 1'b0;
      end else begin
         o_fetch_cmd <= 1'b0;                      // Strobes last one cycle
         o_load_cmd  <= 1'b0;
         if (w_cs_b) begin
            // Deselected so drop the frame
            r_bit_cnt    <= 5'd0;
            r_write      <= 1'b0;
            r_miso_shift <= 8'h00;
            o_cs         <= '0;
         end else begin
            if (w_sck_rise) begin
               if (r_bit_cnt != 5'd16) begin
                  r_bit_cnt <= r_bit_cnt + 5'd1;
               end
               if (r_bit_cnt == 5'd7) begin        // End of byte 1
                  r_write     <= w_byte[7];
                  o_cs        <= cs_onehot_t'(4'b0001 << w_mod_sel);
                  o_fetch_cmd <= ~w_byte[7];       // Reads prefetch the register
               end
               if (r_bit_cnt == 5'd15) begin       // End of byte 2
                  o_load_cmd <= r_write;
               end
            end
            if (w_sck_fall) begin
               if (r_bit_cnt == 5'd8) begin
                  r_miso_shift <= i_data_out;      // Readback is settled by now
               end else begin
                  r_miso_shift <= {r_miso_shift[6:0], 1'b0};
               end
            end
         end
      end
   end

   assign o_spi_miso = r_miso_shift[7];

   //============================================================
   // Assertions
   //============================================================
   a_cs_onehot : assert property (@(posedge i_glob_clock) disable iff (i_reset)
      $onehot0(o_cs));
   a_strobe_excl : assert property (@(posedge i_glob_clock) disable iff (i_reset)
      !(o_fetch_cmd && o_load_cmd));

endmodule

/* design/sys_ctrl.sv */
`timescale 1ns/1ns

module sys_ctrl #(
   parameter radio_ctrl_pkg::data_byte_t FIRMWARE_VERSION = 8'h00
) (
   input  logic                       i_glob_clock,
   input  logic                       i_reset,
   input  radio_ctrl_pkg::ioc_t       i_ioc,
   input  radio_ctrl_pkg::data_byte_t i_data_in,
   input  logic                       i_cs,
   input  logic                       i_fetch_cmd,
   input  logic                       i_load_cmd,
   input  radio_ctrl_pkg::data_byte_t i_error_list,   // One bit per error source
   output radio_ctrl_pkg::data_byte_t o_data_out,
   output logic                       o_soft_reset
);
   import radio_ctrl_pkg::*;

   //============================================================
   // Strobe qualification
   //============================================================
   logic       w_fetch;
   logic       w_load;
   data_byte_t r_scratch;     // Host scratch byte

   assign w_fetch = i_cs & i_fetch_cmd;   // Only when this block is selected
   assign w_load  = i_cs & i_load_cmd;

   //============================================================
   // Register writes
   //============================================================
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         r_scratch    <= 8'h00;
         o_soft_reset <= 1'b0;
      end else begin
         o_soft_reset <= 1'b0;
         if (w_load) begin
            case (i_ioc)
               IOC_SYS_SOFT_RESET: o_soft_reset <= 1'b1;   // Data value ignored
               IOC_SYS_SCRATCH:    r_scratch    <= i_data_in;
               default: ;                                  // Read only or unmapped
            endcase
         end
      end
   end

   //============================================================
   // Readback
   //============================================================
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         o_data_out <= 8'h00;
      end else if (w_fetch) begin
         case (i_ioc)
            IOC_SYS_VERSION: o_data_out <= FIRMWARE_VERSION;
            IOC_SYS_STATUS:  o_data_out <= i_error_list;
            IOC_SYS_SCRATCH: o_data_out <= r_scratch;
            default:         o_data_out <= 8'h00;          // Soft reset reads zero
         endcase
      end
   end

endmodule

/* design/io_ctrl.sv */
`timescale 1ns/1ns

module io_ctrl (
   input  logic                       i_glob_clock,
   input  logic                       i_reset,          // Includes the soft reset
   input  radio_ctrl_pkg::ioc_t       i_ioc,
   input  radio_ctrl_pkg::data_byte_t i_data_in,
   input  logic                       i_cs,
   input  logic                       i_fetch_cmd,
   input  logic                       i_load_cmd,
   input  logic                       i_button,
   input  logic [3:0]                 i_config,         // Board straps
   output radio_ctrl_pkg::data_byte_t o_data_out,
   output logic                       o_config_error,   // Sticky bad mode write
   output logic                       o_rx_h_tx_l,
   output logic                       o_rx_h_tx_l_b,
   output logic                       o_tr_vc1,
   output logic                       o_tr_vc1_b,
   output logic                       o_tr_vc2,
   output logic                       o_shdn_rx_lna,
   output logic                       o_shdn_tx_lna,
   output logic                       o_led0,
   output logic                       o_led1,
   output logic                       o_ldo_2v8_en,
   output logic                       o_mixer_en,
   output logic                       o_mixer_fm
);
   import radio_ctrl_pkg::*;

   //============================================================
   // Mode register and next-mode logic
   //============================================================
   rf_mode_t r_mode;
   rf_mode_t w_mode_next;     // Mode after this cycle's write
   logic     w_mode_bad;      // Write of code 6 or 7
   logic     w_load;
   logic     w_fetch;
   logic     w_tx_mode;
   logic     w_rx_mode;
   logic     w_hipass;

   assign w_load  = i_cs & i_load_cmd;
   assign w_fetch = i_cs & i_fetch_cmd;

   always_comb begin
      w_mode_next = r_mode;
      w_mode_bad  = 1'b0;
      if (w_load && i_ioc == IOC_IO_RF_MODE) begin
         if (i_data_in[2:0] > RF_BYPASS) begin
            w_mode_bad = 1'b1;                   // Keep the old mode
         end else begin
            w_mode_next = rf_mode_t'(i_data_in[2:0]);
         end
      end
   end

   // Decode from the next mode so pins move with the register
   assign w_tx_mode = (w_mode_next == RF_TX_LOWPASS) || (w_mode_next == RF_TX_HIPASS);
   assign w_rx_mode = (w_mode_next == RF_RX_LOWPASS) || (w_mode_next == RF_RX_HIPASS);
   assign w_hipass  = (w_mode_next == RF_RX_HIPASS) || (w_mode_next == RF_TX_HIPASS);

   //============================================================
   // Registers and pins
   //============================================================
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         r_mode         <= RF_LOW_POWER;
         o_config_error <= 1'b0;
         o_rx_h_tx_l    <= 1'b1;   // Low power values
         o_rx_h_tx_l_b  <= 1'b0;
         o_tr_vc1       <= 1'b0;
         o_tr_vc1_b     <= 1'b1;
         o_tr_vc2       <= 1'b0;
         o_shdn_rx_lna  <= 1'b1;   // Both LNAs shut down
         o_shdn_tx_lna  <= 1'b1;
         o_led0         <= 1'b0;
         o_led1         <= 1'b0;
         o_ldo_2v8_en   <= 1'b0;
         o_mixer_en     <= 1'b0;
         o_mixer_fm     <= 1'b0;
      end else begin
         r_mode         <= w_mode_next;
         o_config_error <= o_config_error | w_mode_bad;
         o_rx_h_tx_l    <= ~w_tx_mode;
         o_rx_h_tx_l_b  <= w_tx_mode;
         o_tr_vc1       <= w_hipass;
         o_tr_vc1_b     <= ~w_hipass;
         o_tr_vc2       <= (w_mode_next == RF_BYPASS);
         o_shdn_rx_lna  <= ~w_rx_mode;
         o_shdn_tx_lna  <= ~w_tx_mode;
         if (w_load && i_ioc == IOC_IO_LEDS) begin
            o_led0       <= i_data_in[0];
            o_led1       <= i_data_in[1];
            o_ldo_2v8_en <= i_data_in[2];
         end
         if (w_load && i_ioc == IOC_IO_MIXER) begin
            o_mixer_en <= i_data_in[0];
            o_mixer_fm <= i_data_in[1];
         end
      end
   end

   //============================================================
   // Readback
   //============================================================
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         o_data_out <= 8'h00;
      end else if (w_fetch) begin
         case (i_ioc)
            IOC_IO_RF_MODE: o_data_out <= {5'b00000, r_mode};
            IOC_IO_LEDS:    o_data_out <= {5'b00000, o_ldo_2v8_en, o_led1, o_led0};
            IOC_IO_INPUTS:  o_data_out <= {3'b000, i_button, i_config};
            IOC_IO_MIXER:   o_data_out <= {6'b000000, o_mixer_fm, o_mixer_en};
            default:        o_data_out <= 8'h00;
         endcase
      end
   end

   // Complementary switch drives must never overlap
   a_pin_pairs : assert property (@(posedge i_glob_clock) disable iff (i_reset)
      (o_rx_h_tx_l_b == ~o_rx_h_tx_l) && (o_tr_vc1_b == ~o_tr_vc1));

endmodule

/* design/radio_ctrl_top.sv */
`timescale 1ns/1ns

module radio_ctrl_top #(
   parameter radio_ctrl_pkg::data_byte_t FIRMWARE_VERSION = 8'h12
) (
   input  logic       i_glob_clock,
   input  logic       i_reset,
   // SPI from host
   input  logic       i_mosi,
   input  logic       i_sck,
   input  logic       i_ss,
   output logic       o_miso,
   // Digital straps
   input  logic       i_button,
   input  logic [3:0] i_config,
   // RF front-end
   output logic       o_rx_h_tx_l,
   output logic       o_rx_h_tx_l_b,
   output logic       o_tr_vc1,
   output logic       o_tr_vc1_b,
   output logic       o_tr_vc2,
   output logic       o_shdn_rx_lna,
   output logic       o_shdn_tx_lna,
   // Board controls
   output logic       o_led0,
   output logic       o_led1,
   output logic       o_ldo_2v8_en,
   output logic       o_mixer_en,
   output logic       o_mixer_fm
);
   import radio_ctrl_pkg::*;

   //============================================================
   // Internal signals
   //============================================================
   ioc_t       w_ioc;
   data_byte_t w_rx_data;        // Write data from host
   data_byte_t r_tx_data;        // Registered readback to SPI
   cs_onehot_t w_cs;
   logic       w_fetch;
   logic       w_load;
   logic       w_spi_miso;
   logic       w_soft_reset;
   logic       w_io_reset;       // Hard or soft reset for the I/O block
   logic       w_config_error;
   data_byte_t w_tx_data_sys;
   data_byte_t w_tx_data_io;

   assign w_io_reset = i_reset | w_soft_reset;
   assign o_miso     = i_ss ? 1'b0 : w_spi_miso;   // Quiet while deselected

   //============================================================
   // Instances
   //============================================================
   spi_if spi_if_ins (
      .i_glob_clock (i_glob_clock),
      .i_reset      (i_reset),
      .i_spi_sck    (i_sck),
      .i_spi_mosi   (i_mosi),
      .i_spi_cs_b   (i_ss),
      .i_data_out   (r_tx_data),
      .o_spi_miso   (w_spi_miso),
      .o_ioc        (w_ioc),
      .o_data_in    (w_rx_data),
      .o_cs         (w_cs),
      .o_fetch_cmd  (w_fetch),
      .o_load_cmd   (w_load)
   );

   sys_ctrl #(
      .FIRMWARE_VERSION (FIRMWARE_VERSION)
   ) sys_ctrl_ins (
      .i_glob_clock (i_glob_clock),
      .i_reset      (i_reset),          // Scratch survives a soft reset
      .i_ioc        (w_ioc),
      .i_data_in    (w_rx_data),
      .i_cs         (w_cs[0]),
      .i_fetch_cmd  (w_fetch),
      .i_load_cmd   (w_load),
      .i_error_list ({7'b0000000, w_config_error}),
      .o_data_out   (w_tx_data_sys),
      .o_soft_reset (w_soft_reset)
   );

   io_ctrl io_ctrl_ins (
      .i_glob_clock   (i_glob_clock),
      .i_reset        (w_io_reset),
      .i_ioc          (w_ioc),
      .i_data_in      (w_rx_data),
      .i_cs           (w_cs[1]),
      .i_fetch_cmd    (w_fetch),
      .i_load_cmd     (w_load),
      .i_button       (i_button),
      .i_config       (i_config),
      .o_data_out     (w_tx_data_io),
      .o_config_error (w_config_error),
      .o_rx_h_tx_l    (o_rx_h_tx_l),
      .o_rx_h_tx_l_b  (o_rx_h_tx_l_b),
      .o_tr_vc1       (o_tr_vc1),
      .o_tr_vc1_b     (o_tr_vc1_b),
      .o_tr_vc2       (o_tr_vc2),
      .o_shdn_rx_lna  (o_shdn_rx_lna),
      .o_shdn_tx_lna  (o_shdn_tx_lna),
      .o_led0         (o_led0),
      .o_led1         (o_led1),
      .o_ldo_2v8_en   (o_ldo_2v8_en),
      .o_mixer_en     (o_mixer_en),
      .o_mixer_fm     (o_mixer_fm)
   );

   //============================================================
   // Readback multiplexer
   //============================================================
   always_ff @(posedge i_glob_clock) begin
      if (i_reset) begin
         r_tx_data <= 8'h00;
      end else begin
         case (w_cs)
            4'b0001: r_tx_data <= w_tx_data_sys;
            4'b0010: r_tx_data <= w_tx_data_io;
            4'b0100: r_tx_data <= RESERVED_PATTERN;   // Reserved module
            default: r_tx_data <= 8'h00;              // Unused select or idle
         endcase
      end
   end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic o_glob_clock,
   output logic o_reset
);

   initial begin
      o_glob_clock = 1'b0;
      forever #5 o_glob_clock = ~o_glob_clock;   // 10 ns period
   end

   // Reset held high for the first RESET_CYCLES rising edges
   initial begin
      o_reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge o_glob_clock);
      o_reset <= 1'b0;
   end

endmodule

/* sim/radio_ctrl_tb.sv */
`timescale 1ns/1ns

module radio_ctrl_tb;
   import radio_ctrl_pkg::*;

   //============================================================
   // DUT signals and stimulus storage
   //============================================================
   logic       glob_clock;
   logic       reset;
   logic       spi_mosi;
   logic       spi_sck;
   logic       spi_ss;
   logic       spi_miso;
   logic       button;
   logic [3:0] config_sw;
   logic       rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2;
   logic       shdn_rx_lna, shdn_tx_lna;
   logic       led0, led1, ldo_2v8_en, mixer_en, mixer_fm;

   logic [63:0] op_q[$];           // Op name as packed ASCII
   mod_sel_t    sel_q[$];
   ioc_t        addr_q[$];
   data_byte_t  data_q[$];         // Write byte or expected read byte
   logic [3:0]  cfg_q[$];
   logic        btn_q[$];
   rf_mode_t    mode_q[$];

   integer     seed;
   integer     err_cnt;
   integer     check_cnt;
   integer     cycle_cnt;
   integer     cycle_limit;
   integer     line_idx;
   logic       load_ok;
   logic [2:0] exp_leds;           // ldo, led1, led0 as last written
   logic [1:0] exp_mixer;          // fm, en

   tb_clock_gen #(.RESET_CYCLES(16)) clock_gen_ins (
      .o_glob_clock (glob_clock),
      .o_reset      (reset)
   );

   radio_ctrl_top #(.FIRMWARE_VERSION(8'h12)) uut (
      .i_glob_clock (glob_clock),   .i_reset       (reset),
      .i_mosi       (spi_mosi),     .i_sck         (spi_sck),
      .i_ss         (spi_ss),       .o_miso        (spi_miso),
      .i_button     (button),       .i_config      (config_sw),
      .o_rx_h_tx_l  (rx_h_tx_l),    .o_rx_h_tx_l_b (rx_h_tx_l_b),
      .o_tr_vc1     (tr_vc1),       .o_tr_vc1_b    (tr_vc1_b),
      .o_tr_vc2     (tr_vc2),       .o_shdn_rx_lna (shdn_rx_lna),
      .o_shdn_tx_lna(shdn_tx_lna),  .o_led0        (led0),
      .o_led1       (led1),         .o_ldo_2v8_en  (ldo_2v8_en),
      .o_mixer_en   (mixer_en),     .o_mixer_fm    (mixer_fm)
   );

   //============================================================
   // Compare tasks
   //============================================================
   task automatic check_data(input string name, input data_byte_t got, input data_byte_t exp);
      check_cnt = check_cnt + 1;
      if (got !== exp) begin
         err_cnt = err_cnt + 1;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // Expected pins from the mode decode rule plus the tracked board controls
   task automatic check_rf_pins(input rf_mode_t mode);
      logic       tx;
      logic       rx;
      logic       hp;
      logic [6:0] exp_rf;
      logic [6:0] got_rf;
      logic [4:0] got_brd;
      tx = (mode == RF_TX_LOWPASS) || (mode == RF_TX_HIPASS);
      rx = (mode == RF_RX_LOWPASS) || (mode == RF_RX_HIPASS);
      hp = (mode == RF_RX_HIPASS) || (mode == RF_TX_HIPASS);
      exp_rf  = {~tx, tx, hp, ~hp, mode == RF_BYPASS, ~rx, ~tx};
      got_rf  = {rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2, shdn_rx_lna, shdn_tx_lna};
      got_brd = {ldo_2v8_en, led1, led0, mixer_fm, mixer_en};
      check_cnt = check_cnt + 1;
      if (got_rf !== exp_rf) begin
         err_cnt = err_cnt + 1;
         $display("CHECK FAILED rf_pins mode 0x%h got 0x%h expected 0x%h at %0t",
                  mode, got_rf, exp_rf, $time);
      end
      if (got_brd !== {exp_leds, exp_mixer}) begin
         err_cnt = err_cnt + 1;
         $display("CHECK FAILED board_pins got 0x%h expected 0x%h at %0t",
                  got_brd, {exp_leds, exp_mixer}, $time);
      end
   endtask

   //============================================================
   // Stimulus file and SPI master
   //============================================================
   task automatic load_stimulus(output logic ok);
      integer           fd;
      integer           n;
      integer           line_no;
      logic [8*128-1:0] line_buf;
      logic [63:0]      op;
      logic [31:0]      t_sel, t_addr, t_data, t_cfg, t_btn, t_mode;
      ok = 1'b1;
      line_no = 0;
      fd = $fopen("sim/radio_ctrl_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file sim/radio_ctrl_stimulus.txt");
         ok = 1'b0;
      end else begin
         while (ok && !$feof(fd)) begin
            line_buf = '0;
            op = '0;
            n = $fgets(line_buf, fd);
            line_no = line_no + 1;
            if (n > 0) begin
               n = $sscanf(line_buf, "%s %h %h %h %h %h %h",
                           op, t_sel, t_addr, t_data, t_cfg, t_btn, t_mode);
               if (n >= 1 && op != 64'("#")) begin      // Skip blank and comment lines
                  if (n != 7 || (op != 64'("read") && op != 64'("write")
                                 && op != 64'("pins"))) begin
                     $display("Stimulus line %0d could not be parsed", line_no);
                     ok = 1'b0;
                  end else begin
                     op_q.push_back(op);
                     sel_q.push_back(t_sel[1:0]);
                     addr_q.push_back(t_addr[4:0]);
                     data_q.push_back(t_data[7:0]);
                     cfg_q.push_back(t_cfg[3:0]);
                     btn_q.push_back(t_btn[0]);
                     mode_q.push_back(rf_mode_t'(t_mode[2:0]));
                  end
               end
            end
         end
         $fclose(fd);
         if (ok && op_q.size() == 0) begin
            $display("Stimulus file holds no transactions");
            ok = 1'b0;
         end
      end
   endtask

   // Mode 0 frame sent MSB first with MISO sampled just before each rising SCK
   task automatic spi_transfer(input data_byte_t cmd, input data_byte_t wdata,
                               output data_byte_t rdata);
      logic [15:0] frame;
      integer      i;
      integer      ph;
      frame = {cmd, wdata};
      rdata = 8'h00;
      spi_ss <= 1'b0;
      for (i = 15; i >= 0; i = i - 1) begin
         ph = 4 + ({$random(seed)} % 2);         // Low phase with idle gap
         spi_sck  <= 1'b0;
         spi_mosi <= frame[i];
         repeat (ph - 1) @(posedge glob_clock);
         @(negedge glob_clock);
         if (i < 8) begin
            rdata[i] = spi_miso;
         end
         @(posedge glob_clock);
         spi_sck <= 1'b1;
         ph = 4 + ({$random(seed)} % 2);
         repeat (ph) @(posedge glob_clock);
      end
      spi_sck <= 1'b0;
      repeat (4) @(posedge glob_clock);
      spi_ss <= 1'b1;
      repeat (6) @(posedge glob_clock);          // Let the deselect reach the DUT
   endtask

   task automatic run_line(input integer idx);
      data_byte_t cmd;
      data_byte_t rdata;
      data_byte_t wdata;
      logic       is_write;
      @(posedge glob_clock);
      config_sw <= cfg_q[idx];
      button    <= btn_q[idx];
      wdata     = data_q[idx];
      is_write  = (op_q[idx] == 64'("write"));
      if (op_q[idx] == 64'("pins")) begin
         repeat (3) @(posedge glob_clock);
         @(negedge glob_clock);
         check_rf_pins(mode_q[idx]);
      end else begin
         cmd = {is_write, sel_q[idx], addr_q[idx]};
         spi_transfer(cmd, wdata, rdata);
         if (is_write) begin
            if (sel_q[idx] == 2'd1 && addr_q[idx] == IOC_IO_LEDS) begin
               exp_leds = wdata[2:0];
            end
            if (sel_q[idx] == 2'd1 && addr_q[idx] == IOC_IO_MIXER) begin
               exp_mixer = wdata[1:0];
            end
            if (sel_q[idx] == 2'd0 && addr_q[idx] == IOC_SYS_SOFT_RESET) begin
               exp_leds  = 3'b000;               // I/O block back at reset values
               exp_mixer = 2'b00;
            end
         end else begin
            check_data($sformatf("o_miso sel %0d ioc 0x%h", sel_q[idx], addr_q[idx]),
                       rdata, wdata);
         end
      end
   endtask

   //============================================================
   // Timeout and main sequence
   //============================================================
   always @(posedge glob_clock) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, the transactions did not complete", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   initial begin
      spi_mosi  <= 1'b0;
      spi_sck   <= 1'b0;
      spi_ss    <= 1'b1;                          // Deselected
      button    <= 1'b0;
      config_sw <= 4'h0;
      seed        = 56;
      err_cnt     = 0;
      check_cnt   = 0;
      cycle_cnt   = 0;
      cycle_limit = 500;
      exp_leds    = 3'b000;
      exp_mixer   = 2'b00;
      load_stimulus(load_ok);
      if (!load_ok) begin
         $display("test failed");
         $finish;
      end else begin
         cycle_limit = op_q.size() * 200 + 500;
         @(posedge glob_clock);                   // Reset is high from the first edge
         while (reset) @(posedge glob_clock);
         repeat (2) @(posedge glob_clock);
         for (line_idx = 0; line_idx < op_q.size(); line_idx = line_idx + 1) begin
            run_line(line_idx);
         end
         $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
         if (err_cnt == 0) begin
            $display("test passed");
         end else begin
            $display("test failed");
         end
         $finish;
      end
   end

endmodule

/* sim/radio_ctrl_stimulus.txt */
# op sel addr data cfg btn mode, all hex; data is the write byte or the expected read byte
# pins lines check the RF pins against mode and the board pins against the last writes
pins  0 00 00 0 0 0
read  0 00 12 0 0 0
write 0 03 5a 0 0 0
read  0 03 5a 0 0 0
read  2 00 a5 0 0 0
read  3 05 00 0 0 0
write 1 01 01 0 0 1
pins  0 00 00 0 0 1
read  1 01 01 0 0 1
write 1 01 02 0 0 2
pins  0 00 00 0 0 2
read  1 01 02 0 0 2
write 1 01 03 0 0 3
pins  0 00 00 0 0 3
read  1 01 03 0 0 3
write 1 01 04 0 0 4
pins  0 00 00 0 0 4
read  1 01 04 0 0 4
write 1 01 05 0 0 5
pins  0 00 00 0 0 5
read  1 01 05 0 0 5
write 1 02 05 0 0 5
write 1 04 02 0 0 5
pins  0 00 00 0 0 5
write 1 02 07 0 0 5
write 1 04 03 0 0 5
pins  0 00 00 0 0 5
read  1 02 07 0 0 5
read  1 04 03 0 0 5
read  1 03 1b b 1 5
read  1 03 06 6 0 5
write 1 01 06 0 0 5
pins  0 00 00 0 0 5
read  1 01 05 0 0 5
read  0 01 01 0 0 5
write 0 02 00 0 0 0
pins  0 00 00 0 0 0
read  0 01 00 0 0 0
read  1 01 00 0 0 0
read  0 03 5a 0 0 0

/* sim.f */
design/radio_ctrl_pkg.sv
design/spi_if.sv
design/sys_ctrl.sv
design/io_ctrl.sv
design/radio_ctrl_top.sv
sim/tb_clock_gen.sv
sim/radio_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the radio control testbench with Verilator.
# The run passes only if the pass message appears in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module radio_ctrl_tb \
   -Mdir obj_dir -o radio_ctrl_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/radio_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1
